// File: verilog/io_pkg.sv
package io_pkg;

  // --------------------
  // bus geometry
  // --------------------
  localparam int IO_ADR_W = 16;  // master address width
  localparam int IO_DAT_W = 8;   // master data width

  // --------------------
  // address map
  // --------------------
  localparam logic [11:0] BTN_LED_BASE = 12'hB20;  // adr[15:4], buttons in / leds out
  localparam logic [11:0] SW_BASE      = 12'hB22;  // adr[15:4], slide switches
  localparam logic [1:0]  RAM_SEL      = 2'b01;    // adr[15:14], 4000..7fff

  // returned on reads that hit no window
  localparam logic [IO_DAT_W-1:0] UNMAPPED_DATA = 8'hFF;

  // --------------------
  // defaults, overridden from the top level
  // --------------------
  localparam int DEF_RAM_AW          = 10;  // 1 KiB, aliases inside the 16 KiB window
  localparam int DEF_DEBOUNCE_CYCLES = 16;
  localparam int NUM_BTNS            = 5;   // right, left, down, up, center

  // which window an access lands in
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_BTN_LED,
    REGION_SW,
    REGION_RAM
  } io_region_e;

  // bus direction
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } io_op_e;

endpackage

// File: verilog/io_bus_if.sv
`timescale 1ns/1ns

// request from the decode stage, responses from the execute stage
interface io_bus_if import io_pkg::*; ();

  logic                req_valid;  // one-cycle pulse per accepted access
  io_region_e          region;     // held until next request
  io_op_e              op;
  logic [IO_ADR_W-1:0] adr;
  logic [IO_DAT_W-1:0] wdat;

  logic [IO_DAT_W-1:0] regs_rdat;  // register windows + unmapped
  logic                regs_done;
  logic [IO_DAT_W-1:0] ram_rdat;   // scratch ram
  logic                ram_done;

  modport dec (
    output req_valid, region, op, adr, wdat
  );

  // each execute block drives only the response of its own windows
  modport exe (
    input  req_valid, region, op, adr, wdat,
    output regs_done, regs_rdat, ram_done, ram_rdat
  );

  modport res (
    input req_valid, region, op, adr, wdat,
    input regs_done, regs_rdat, ram_done, ram_rdat
  );

endinterface

// File: verilog/btn_debounce.sv
`timescale 1ns/1ns

module btn_debounce import io_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic btn_i,   // raw pad, asynchronous
  output logic btn_o    // clean level
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

  logic             sync_q1;
  logic             sync_q2;
  logic [CNT_W-1:0] cnt_q;    // cycles the input has disagreed

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      cnt_q   <= '0;
      btn_o   <= 1'b0;
    end else begin
      sync_q1 <= btn_i;    // 2-flop sync
      sync_q2 <= sync_q1;
      if (sync_q2 == btn_o) begin
        cnt_q <= '0;       // bounce back, restart
      end else if (cnt_q == CNT_LAST) begin
        btn_o <= sync_q2;  // stable long enough
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: verilog/io_addr_decode.sv
`timescale 1ns/1ns

module io_addr_decode import io_pkg::*; (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [IO_ADR_W-1:0] adr_i,
  input  logic [IO_DAT_W-1:0] dat_i,
  input  logic                ack_i,     // registered ack from the return stage
  io_bus_if.dec               bus
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } dec_state_e;

  dec_state_e state_q;
  io_region_e region_d;
  logic       new_req;

  // master holds cyc/stb until ack, so only take it when idle
  assign new_req = cyc_i && stb_i && (state_q == ST_IDLE);

  // window select on the upper address bits
  always_comb begin
    if (adr_i[IO_ADR_W-1:4] == BTN_LED_BASE) begin
      region_d = REGION_BTN_LED;
    end else if (adr_i[IO_ADR_W-1:4] == SW_BASE) begin
      region_d = REGION_SW;
    end else if (adr_i[IO_ADR_W-1:IO_ADR_W-2] == RAM_SEL) begin
      region_d = REGION_RAM;
    end else begin
      region_d = REGION_NONE;  // falls through to unmapped
    end
  end

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= ST_IDLE;
      bus.req_valid <= 1'b0;
      bus.region    <= REGION_NONE;
      bus.op        <= OP_READ;
    end else begin
      bus.req_valid <= new_req;  // single pulse, state blocks a repeat
      if (new_req) begin
        bus.region <= region_d;
        bus.op     <= we_i ? OP_WRITE : OP_READ;
      end
      case (state_q)
        ST_IDLE: if (new_req) state_q <= ST_BUSY;
        ST_BUSY: if (ack_i) state_q <= ST_IDLE;  // free on the edge after ack
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (new_req) begin
      bus.adr  <= adr_i;
      bus.wdat <= dat_i;
    end
  end

  // the return stage only acknowledges a request in flight
  a_ack_in_flight: assert property (@(posedge clk) disable iff (!arst_n_i)
    ack_i |-> state_q == ST_BUSY);

  // at most one request in flight
  a_req_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus.req_valid |=> !bus.req_valid);

endmodule

// File: verilog/io_periph_regs.sv
`timescale 1ns/1ns

module io_periph_regs import io_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic [NUM_BTNS-1:0] btn_i,   // [0] right .. [4] center
  input  logic [IO_DAT_W-1:0] sw_i,
  output logic [IO_DAT_W-1:0] led_o,
  io_bus_if.exe               bus
);

  logic [NUM_BTNS-1:0] btn_db;   // debounced, same bit order as btn_i
  logic                reg_hit;  // everything that isn't ram lands here
  logic                led_wr;

  // --------------------
  // buttons
  // --------------------
  for (genvar i = 0; i < NUM_BTNS; i++) begin : g_btn
    btn_debounce #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_db (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .btn_i    (btn_i[i]),
      .btn_o    (btn_db[i])
    );
  end

  // --------------------
  // bus response
  // --------------------
  // answers same cycle as req_valid, unmapped included
  assign reg_hit       = bus.req_valid && (bus.region != REGION_RAM);
  assign bus.regs_done = reg_hit;

  always_comb begin
    case (bus.region)
      // 000, center, up, down, left, right
      REGION_BTN_LED: bus.regs_rdat = {{(IO_DAT_W-NUM_BTNS){1'b0}}, btn_db};
      REGION_SW:      bus.regs_rdat = sw_i;           // straight from the pins
      default:        bus.regs_rdat = UNMAPPED_DATA;  // unmapped, ram ignored
    endcase
  end

  // --------------------
  // leds
  // --------------------
  // switch and unmapped writes complete with no effect
  assign led_wr = reg_hit && (bus.region == REGION_BTN_LED) && (bus.op == OP_WRITE);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_o <= '0;
    end else if (led_wr) begin
      led_o <= bus.wdat;  // visible from edge N+1
    end
  end

endmodule

// File: verilog/io_scratch_ram.sv
`timescale 1ns/1ns

module io_scratch_ram import io_pkg::*; #(
  parameter int RAM_AW = DEF_RAM_AW
) (
  input  logic  clk,
  input  logic  arst_n_i,
  io_bus_if.exe bus
);

  localparam int RAM_DEPTH = 1 << RAM_AW;

  logic [IO_DAT_W-1:0] mem [RAM_DEPTH];  // stands in for the packet buffer
  logic [RAM_AW-1:0]   ram_adr;
  logic                ram_req;
  logic                wr_en;
  logic                rd_en;
  logic                rd_pend_q;        // read data ready next cycle
  logic [IO_DAT_W-1:0] rd_dat_q;

  // low bits only, window aliases every RAM_DEPTH bytes
  assign ram_adr = bus.adr[RAM_AW-1:0];
  assign ram_req = bus.req_valid && (bus.region == REGION_RAM);
  assign wr_en   = ram_req && (bus.op == OP_WRITE);
  assign rd_en   = ram_req && (bus.op == OP_READ);

  // --------------------
  // array
  // --------------------
  // address was registered in decode, data registered here
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[ram_adr] <= bus.wdat;  // lands at edge N+1
    end
    if (rd_en) begin
      rd_dat_q <= mem[ram_adr];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_en;
    end
  end

  // writes done at once, reads one cycle later
  assign bus.ram_done = wr_en || rd_pend_q;
  assign bus.ram_rdat = rd_dat_q;

  // region is held by decode through the read's extra cycle
  a_ram_region: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus.ram_done |-> bus.region == REGION_RAM);

endmodule

// File: verilog/io_read_return.sv
`timescale 1ns/1ns

module io_read_return import io_pkg::*; (
  input  logic                clk,
  input  logic                arst_n_i,
  output logic                ack_o,
  output logic [IO_DAT_W-1:0] dat_o,
  io_bus_if.res               bus
);

  logic                done_any;
  logic [IO_DAT_W-1:0] resp_dat_d;
  logic                resp_valid_q;  // response latch stage
  logic [IO_DAT_W-1:0] resp_dat_q;

  assign done_any = bus.regs_done || bus.ram_done;

  // region is still the captured one, decode holds it
  always_comb begin
    if (bus.op == OP_WRITE) begin
      resp_dat_d = '0;  // nothing to return on writes
    end else if (bus.region == REGION_RAM) begin
      resp_dat_d = bus.ram_rdat;
    end else begin
      resp_dat_d = bus.regs_rdat;
    end
  end

  // --------------------
  // response latch
  // --------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= done_any;
    end
  end

  always_ff @(posedge clk) begin
    if (done_any) begin
      resp_dat_q <= resp_dat_d;
    end
  end

  // --------------------
  // bus side
  // --------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o <= 1'b0;
      dat_o <= '0;
    end else begin
      ack_o <= resp_valid_q;  // single pulse per done
      if (resp_valid_q) begin
        dat_o <= resp_dat_q;  // held until the next access
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    ack_o |=> !ack_o);

endmodule

// File: verilog/butterfly_io_top.sv
`timescale 1ns/1ns

module butterfly_io_top import io_pkg::*; #(
  parameter int RAM_AW          = DEF_RAM_AW,
  parameter int DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES
) (
  input  logic                clk,
  input  logic                arst_n_i,
  // master port
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [IO_ADR_W-1:0] adr_i,
  input  logic [IO_DAT_W-1:0] dat_i,
  output logic                ack_o,
  output logic [IO_DAT_W-1:0] dat_o,
  // board pins
  input  logic [NUM_BTNS-1:0] btn_i,
  input  logic [IO_DAT_W-1:0] sw_i,
  output logic [IO_DAT_W-1:0] led_o
);

  io_bus_if bus ();

  // --------------------
  // decode
  // --------------------
  io_addr_decode u_decode (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .adr_i    (adr_i),
    .dat_i    (dat_i),
    .ack_i    (ack_o),   // frees the decoder
    .bus      (bus.dec)
  );

  // --------------------
  // execute
  // --------------------
  io_periph_regs #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_regs (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .btn_i    (btn_i),
    .sw_i     (sw_i),
    .led_o    (led_o),
    .bus      (bus.exe)
  );

  io_scratch_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .bus      (bus.exe)
  );

  // --------------------
  // result
  // --------------------
  io_read_return u_return (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .ack_o    (ack_o),
    .dat_o    (dat_o),
    .bus      (bus.res)
  );

endmodule

// File: test/butterfly_io_tb.sv
`timescale 1ns/1ns

module butterfly_io_tb import io_pkg::*; ();

  localparam int RAM_AW          = 10;
  localparam int DEBOUNCE_CYCLES = 4;
  localparam int ACK_WAIT_MAX    = 10;    // cycles a bus access may wait for ack
  localparam int MAX_CYCLES      = 2000;  // ~60 accesses of <= 14 cycles plus button settling

  logic                clk;
  logic                arst_n_i;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  logic [IO_ADR_W-1:0] adr_i;
  logic [IO_DAT_W-1:0] dat_i;
  logic                ack_o;
  logic [IO_DAT_W-1:0] dat_o;
  logic [NUM_BTNS-1:0] btn_i;
  logic [IO_DAT_W-1:0] sw_i;
  logic [IO_DAT_W-1:0] led_o;

  logic [31:0]         rng_state = 32'h2a07_a7fb;
  logic [IO_DAT_W-1:0] model [1 << RAM_AW];  // ram reference, low address bits
  int                  cycle_cnt = 0;
  int                  n_tests   = 0;
  int                  n_checks  = 0;
  int                  n_errors  = 0;
  int                  test_err_start;

  butterfly_io_top #(
    .RAM_AW          (RAM_AW),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) DUT (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .adr_i    (adr_i),
    .dat_i    (dat_i),
    .ack_o    (ack_o),
    .dat_o    (dat_o),
    .btn_i    (btn_i),
    .sw_i     (sw_i),
    .led_o    (led_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // --------------------
  // watchdog
  // --------------------
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, the tests did not finish", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_data(input logic [IO_DAT_W-1:0] got, input logic [IO_DAT_W-1:0] exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_region_latency(input io_region_e region, input io_op_e op,
                                      input int measured, input string what);
    int exp;
    exp = (region == REGION_RAM && op == OP_READ) ? 3 : 2;  // ram reads take one more
    n_checks++;
    if (measured != exp) begin
      n_errors++;
      $display("error at %0t ns: %s took %0d cycles, expected %0d", $time, what, measured, exp);
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic bus_access(input io_op_e op, input logic [IO_ADR_W-1:0] adr,
                            input logic [IO_DAT_W-1:0] wdat,
                            output logic [IO_DAT_W-1:0] rdat, output int lat);
    int waited;
    rdat = '0;
    lat  = -1;
    @(posedge clk);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= (op == OP_WRITE);
    adr_i <= adr;
    dat_i <= wdat;
    @(posedge clk);  // edge N, request sampled
    waited = 1;
    while (!ack_o && waited < ACK_WAIT_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (ack_o) begin
      rdat = dat_o;       // valid with ack
      lat  = waited - 2;  // ack raised at N+lat, seen one edge later
    end else begin
      n_errors++;
      $display("access to %h got no acknowledge within %0d cycles", adr, ACK_WAIT_MAX);
    end
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    @(posedge clk);
    if (ack_o) begin
      n_errors++;
      $display("ack for access to %h lasted more than one cycle", adr);
    end
  endtask

  task automatic bus_write(input logic [IO_ADR_W-1:0] adr, input logic [IO_DAT_W-1:0] wdat,
                           output int lat);
    logic [IO_DAT_W-1:0] unused_rdat;
    bus_access(OP_WRITE, adr, wdat, unused_rdat, lat);
  endtask

  task automatic bus_read(input logic [IO_ADR_W-1:0] adr, output logic [IO_DAT_W-1:0] rdat,
                          output int lat);
    bus_access(OP_READ, adr, '0, rdat, lat);
  endtask

  task automatic start_test();
    n_tests++;
    test_err_start = n_errors;
  endtask

  task automatic report_test(input string name);
    if (n_errors == test_err_start) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_errors - test_err_start);
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic test_reset();
    start_test();
    check_data(IO_DAT_W'(ack_o), '0, "ack_o after reset");
    check_data(led_o, '0, "led_o after reset");
    check_data(dat_o, '0, "dat_o after reset");
    report_test("reset");
  endtask

  task automatic test_led();
    logic [31:0]         r;
    logic [IO_DAT_W-1:0] held;
    int                  lat;
    start_test();
    for (int i = 0; i < 4; i++) begin
      r = next_rand();
      bus_write({BTN_LED_BASE, r[11:8]}, r[7:0], lat);  // any offset in the window
      check_region_latency(REGION_BTN_LED, OP_WRITE, lat, "led write");
      check_data(led_o, r[7:0], "led_o after write");
      held = r[7:0];
    end
    r = next_rand();
    bus_write({SW_BASE, r[11:8]}, ~held, lat);  // discarded
    check_region_latency(REGION_SW, OP_WRITE, lat, "switch write");
    check_data(led_o, held, "led_o after switch write");
    report_test("led");
  endtask

  task automatic test_switches_buttons();
    logic [31:0]         r;
    logic [IO_DAT_W-1:0] rd;
    logic                center;
    logic                up;
    logic                down;
    logic                left;
    logic                right;
    int                  lat;
    start_test();
    r = next_rand();
    @(posedge clk);
    sw_i <= r[7:0];
    bus_read({SW_BASE, r[11:8]}, rd, lat);
    check_data(rd, r[7:0], "switch read");
    check_region_latency(REGION_SW, OP_READ, lat, "switch read");
    center = 1'b1;
    up     = 1'b0;
    down   = 1'b1;
    left   = 1'b1;
    right  = 1'b0;
    @(posedge clk);
    btn_i <= {center, up, down, left, right};  // btn_i[0] is right
    repeat (DEBOUNCE_CYCLES + 2 + 4) @(posedge clk);  // sync, count, margin
    bus_read({BTN_LED_BASE, 4'h0}, rd, lat);
    check_data(rd, {3'b000, center, up, down, left, right}, "button read");
    check_region_latency(REGION_BTN_LED, OP_READ, lat, "button read");
    // short glitch on right, one cycle under the debounce length
    @(posedge clk);
    btn_i <= {center, up, down, left, ~right};
    repeat (DEBOUNCE_CYCLES - 1) @(posedge clk);
    btn_i <= {center, up, down, left, right};
    bus_read({BTN_LED_BASE, 4'h0}, rd, lat);  // a shorter count would show it here
    check_data(rd, {3'b000, center, up, down, left, right}, "button read during glitch");
    repeat (DEBOUNCE_CYCLES + 2 + 4) @(posedge clk);
    bus_read({BTN_LED_BASE, 4'h0}, rd, lat);
    check_data(rd, {3'b000, center, up, down, left, right}, "button read after glitch");
    report_test("switches and buttons");
  endtask

  task automatic test_ram();
    logic [31:0]         r;
    logic [IO_ADR_W-1:0] adrs [16];
    logic [RAM_AW-1:0]   idx;
    logic [IO_DAT_W-1:0] rd;
    int                  lat;
    start_test();
    for (int i = 0; i < 16; i++) begin
      r       = next_rand();
      adrs[i] = {RAM_SEL, r[21:8]};  // anywhere in 4000..7fff
      idx     = adrs[i][RAM_AW-1:0];
      model[idx] = r[7:0];
      bus_write(adrs[i], r[7:0], lat);
      check_region_latency(REGION_RAM, OP_WRITE, lat, "ram write");
    end
    for (int i = 0; i < 16; i++) begin
      idx = adrs[i][RAM_AW-1:0];
      bus_read(adrs[i], rd, lat);
      check_data(rd, model[idx], "ram read");
      check_region_latency(REGION_RAM, OP_READ, lat, "ram read");
    end
    // 1 KiB alias
    bus_write(16'h4000, 8'h5A, lat);
    bus_read(16'h4400, rd, lat);
    check_data(rd, 8'h5A, "ram alias 4400");
    bus_write(16'h4400, 8'hA5, lat);
    bus_read(16'h4000, rd, lat);
    check_data(rd, 8'hA5, "ram alias 4000");
    report_test("ram");
  endtask

  task automatic test_unmapped();
    logic [IO_DAT_W-1:0] rd;
    logic [IO_DAT_W-1:0] led_before;
    int                  lat;
    start_test();
    bus_read(16'h1000, rd, lat);
    check_data(rd, 8'hFF, "unmapped read");
    check_region_latency(REGION_NONE, OP_READ, lat, "unmapped read");
    led_before = led_o;
    bus_write(16'h1000, ~led_before, lat);  // must go nowhere
    check_region_latency(REGION_NONE, OP_WRITE, lat, "unmapped write");
    check_data(led_o, led_before, "led_o after unmapped write");
    bus_read(16'h1000, rd, lat);
    check_data(rd, 8'hFF, "unmapped read after write");
    report_test("unmapped");
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    arst_n_i <= 1'b0;
    cyc_i    <= 1'b0;
    stb_i    <= 1'b0;
    we_i     <= 1'b0;
    adr_i    <= '0;
    dat_i    <= '0;
    btn_i    <= '0;
    sw_i     <= '0;
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);
    test_reset();
    test_led();
    test_switches_buttons();
    test_ram();
    test_unmapped();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: butterfly_io.f
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/btn_debounce.sv
verilog/io_addr_decode.sv
verilog/io_periph_regs.sv
verilog/io_scratch_ram.sv
verilog/io_read_return.sv
verilog/butterfly_io_top.sv
test/butterfly_io_tb.sv

// File: Makefile
# Verilator build and run for butterfly_io

VERILATOR ?= verilator
TOP       ?= butterfly_io_tb
FILELIST  ?= butterfly_io.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status follows the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
